// ==== list.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_if.sv
hw/decode_if.sv
hw/bus_if.sv
hw/px.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/cpu.sv
tb/bus_memory.sv
tb/cpu_tb.sv

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_tb;

	logic __clk;
	logic reset;
	logic start_;
	logic [15:0] kl;
	logic run;
	logic hlt_n_;
	logic awaria_;
	logic [15:0] w;
	logic dr_;
	logic dw_;
	logic [15:0] dad_;
	logic [15:0] ddt_;
	logic [15:0] rdt_;
	logic rok_;
	logic ren_;

	logic [15:0] image [0:255];
	logic [15:0] model_mem [0:255];
	logic [15:0] model_w;
	logic model_alarm;
	integer org;
	integer errors;
	integer tests;

	cpu DUT (.__clk(__clk), .reset(reset), .start_(start_), .kl(kl), .run(run),
		.hlt_n_(hlt_n_), .awaria_(awaria_), .w(w), .dr_(dr_), .dw_(dw_), .dad_(dad_),
		.ddt_(ddt_), .rdt_(rdt_), .rok_(rok_), .ren_(ren_));

	bus_memory memory (.__clk(__clk), .dr_(dr_), .dw_(dw_), .dad_(dad_), .ddt_(ddt_),
		.rdt_(rdt_), .rok_(rok_), .ren_(ren_));

	initial begin
		__clk = 1'b0;
		forever #20 __clk = ~__clk;
	end

	// --------------------
	// Program building

	function automatic logic [15:0] enc(input logic [3:0] op, input integer a,
		input integer c, input integer imm);
		return {op, a[2:0], c[2:0], imm[5:0]};
	endfunction

	function automatic void clear_image();
		integer i;
		logic [7:0] a;

		for (i = 0; i < 256; i++) begin
			a = i;
			image[i] = {~a, a ^ 8'h3c};
		end
	endfunction

	function automatic void emit(input logic [15:0] word);
		image[org] = word;
		org++;
	endfunction

	// Instruction set model, runs on model_mem from the entry address
	function automatic void model_run(input logic [15:0] entry);
		logic [15:0] r [0:7];
		logic [15:0] pc;
		logic [15:0] ir;
		logic [15:0] imm;
		logic [15:0] ea;
		logic [2:0] a;
		logic [2:0] c;
		logic stop;
		integer i;
		integer steps;

		for (i = 0; i < 8; i++)
			r[i] = '0;
		pc = entry;
		stop = 1'b0;
		steps = 0;
		model_w = '0;
		model_alarm = 1'b0;
		while (!stop && steps < 1000) begin
			steps++;
			if (pc > 16'd255) begin
				model_alarm = 1'b1;
				stop = 1'b1;
			end else begin
				ir = model_mem[pc[7:0]];
				a = ir[11:9];
				c = ir[8:6];
				imm = {{10{ir[5]}}, ir[5:0]};
				ea = r[c] + imm;
				pc = pc + 16'd1;
				case (ir[15:12])
					`CPU_OP_LWT: r[a] = imm;
					`CPU_OP_AW: r[a] = r[a] + r[c];
					`CPU_OP_SW: r[a] = r[a] - r[c];
					`CPU_OP_NR: r[a] = r[a] & r[c];
					`CPU_OP_OR: r[a] = r[a] | r[c];
					`CPU_OP_LW, `CPU_OP_RW: begin
						if (ea > 16'd255) begin
							model_alarm = 1'b1;
							stop = 1'b1;
						end else if (ir[15:12] == `CPU_OP_LW) begin
							r[a] = model_mem[ea[7:0]];
							model_w = r[a];
						end else begin
							model_mem[ea[7:0]] = r[a];
						end
					end
					`CPU_OP_UJ: pc = ea;
					`CPU_OP_HLT: stop = 1'b1;
					default: begin
						model_alarm = 1'b1;
						stop = 1'b1;
					end
				endcase
				case (ir[15:12])
					`CPU_OP_LWT, `CPU_OP_AW, `CPU_OP_SW, `CPU_OP_NR, `CPU_OP_OR: model_w = r[a];
					default: ;
				endcase
			end
		end
	endfunction

	// --------------------
	// Running a program

	task automatic apply_reset();
		@(posedge __clk);
		#5;
		reset = 1'b1;
		start_ = 1'b1;
		repeat (16) @(posedge __clk);
		#5;
		reset = 1'b0;
	endtask

	task automatic run_program(input logic [15:0] entry);
		integer i;
		integer cycles;

		tests++;
		for (i = 0; i < 256; i++) begin
			memory.cells[i] = image[i];
			model_mem[i] = image[i];
		end
		model_run(entry);
		apply_reset();
		kl = entry;
		start_ = 1'b0;
		@(posedge __clk);
		#5;
		start_ = 1'b1;
		cycles = 0;
		while (hlt_n_ && awaria_ && cycles < 4000) begin
			@(negedge __clk);
			cycles++;
		end
		if (cycles >= 4000) begin
			$display("Program at %0d did not stop within 4000 cycles", entry);
			errors++;
		end
		// run drops one cycle after the lamp
		repeat (2) @(negedge __clk);
		if (run !== 1'b0 || hlt_n_ !== model_alarm || awaria_ !== !model_alarm) begin
			$display("MISMATCH at %0t: lamps run=%b hlt_n_=%b awaria_=%b, expected 0 %b %b",
				$time, run, hlt_n_, awaria_, model_alarm, !model_alarm);
			errors++;
		end
		if (w !== model_w) begin
			$display("MISMATCH at %0t: w=%h, expected %h", $time, w, model_w);
			errors++;
		end
		for (i = 0; i < 256; i++) begin
			if (memory.cells[i] !== model_mem[i]) begin
				$display("MISMATCH at %0t: memory[%0d]=%h, expected %h",
					$time, i, memory.cells[i], model_mem[i]);
				errors++;
			end
		end
	endtask

	// --------------------
	// Directed tests

	task automatic reset_test();
		tests++;
		apply_reset();
		@(negedge __clk);
		if (run !== 1'b0 || hlt_n_ !== 1'b1 || awaria_ !== 1'b1 || w !== 16'h0000) begin
			$display("MISMATCH at %0t: after reset run=%b hlt_n_=%b awaria_=%b w=%h",
				$time, run, hlt_n_, awaria_, w);
			errors++;
		end
		if (dr_ !== 1'b1 || dw_ !== 1'b1 || dad_ !== 16'hffff || ddt_ !== 16'hffff) begin
			$display("MISMATCH at %0t: after reset dr_=%b dw_=%b dad_=%h ddt_=%h",
				$time, dr_, dw_, dad_, ddt_);
			errors++;
		end
	endtask

	task automatic alu_test();
		integer i;

		clear_image();
		org = 64;
		emit(enc(`CPU_OP_LWT, 2, 0, -7));
		for (i = 3; i <= 6; i++)
			emit(enc(`CPU_OP_LWT, i, 0, 13));
		emit(enc(`CPU_OP_AW, 3, 2, 0));
		emit(enc(`CPU_OP_SW, 4, 2, 0));
		emit(enc(`CPU_OP_NR, 5, 2, 0));
		emit(enc(`CPU_OP_OR, 6, 2, 0));
		for (i = 3; i <= 6; i++)
			emit(enc(`CPU_OP_RW, i, 0, 17 + i));
		emit(enc(`CPU_OP_HLT, 0, 0, 0));
		run_program(64);
	endtask

	task automatic load_store_test();
		clear_image();
		org = 96;
		emit(enc(`CPU_OP_LWT, 1, 0, 30));
		emit(enc(`CPU_OP_LW, 2, 1, 5));
		emit(enc(`CPU_OP_LW, 3, 1, -10));
		emit(enc(`CPU_OP_AW, 2, 3, 0));
		emit(enc(`CPU_OP_RW, 2, 1, 12));
		emit(enc(`CPU_OP_RW, 3, 1, -1));
		emit(enc(`CPU_OP_LW, 4, 1, 12));
		emit(enc(`CPU_OP_RW, 4, 1, 13));
		emit(enc(`CPU_OP_HLT, 0, 0, 0));
		run_program(96);
	endtask

	task automatic jump_test();
		clear_image();
		org = 128;
		emit(enc(`CPU_OP_LWT, 1, 0, 7));
		emit(enc(`CPU_OP_LWT, 2, 0, 16));
		emit(enc(`CPU_OP_AW, 2, 2, 0));
		emit(enc(`CPU_OP_AW, 2, 2, 0));
		emit(enc(`CPU_OP_AW, 2, 2, 0));
		// Jump from 133 to 136, skipping two stores
		emit(enc(`CPU_OP_UJ, 0, 2, 8));
		emit(enc(`CPU_OP_RW, 1, 0, 50));
		emit(enc(`CPU_OP_RW, 1, 0, 51));
		emit(enc(`CPU_OP_RW, 1, 0, 52));
		emit(enc(`CPU_OP_HLT, 0, 0, 0));
		run_program(128);
	endtask

	task automatic nomem_test();
		integer i;

		clear_image();
		org = 160;
		emit(enc(`CPU_OP_LWT, 2, 0, 18));
		for (i = 0; i < 4; i++)
			emit(enc(`CPU_OP_AW, 2, 2, 0));
		// 288 + 12 lands outside the memory
		emit(enc(`CPU_OP_LW, 3, 2, 12));
		emit(enc(`CPU_OP_RW, 2, 0, 60));
		emit(enc(`CPU_OP_HLT, 0, 0, 0));
		run_program(160);
	endtask

	task automatic illegal_test();
		clear_image();
		org = 192;
		emit(enc(`CPU_OP_LWT, 1, 0, 9));
		emit(enc(`CPU_OP_RW, 1, 0, 61));
		emit(enc(4'h7, 0, 0, 0));
		emit(enc(`CPU_OP_RW, 1, 0, 62));
		emit(enc(`CPU_OP_HLT, 0, 0, 0));
		run_program(192);
	endtask

	initial begin
		reset = 1'b1;
		start_ = 1'b1;
		kl = 16'h0000;
		errors = 0;
		tests = 0;
		reset_test();
		alu_test();
		load_store_test();
		jump_test();
		nomem_test();
		illegal_test();
		errors = errors + memory.faults;
		$display("Finished %0d tests with %0d errors", tests, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== tb/bus_memory.sv ====
`timescale 1ns/1ps

// Word memory on the active-low system bus
// Addresses 0..255 answer with rok_, everything above with ren_
module bus_memory (
	input logic __clk,
	input logic dr_,
	input logic dw_,
	input logic [15:0] dad_,
	input logic [15:0] ddt_,
	output logic [15:0] rdt_,
	output logic rok_,
	output logic ren_
);

	logic [15:0] cells [0:255];
	logic [15:0] addr;
	integer seed;
	integer delay;
	integer held;
	integer faults;

	initial begin
		seed = 32'h3aaf6725;
		faults = 0;
		rdt_ = 16'hffff;
		rok_ = 1'b1;
		ren_ = 1'b1;
	end

	always begin
		@(posedge __clk);
		#5;
		if (!dr_ || !dw_) begin
			addr = ~dad_;
			// Answer after 1 to 4 cycles
			delay = 1 + ($random(seed) & 3);
			repeat (delay) @(posedge __clk);
			#5;
			if (addr > 16'd255) begin
				ren_ = 1'b0;
			end else begin
				if (!dw_)
					cells[addr[7:0]] = ~ddt_;
				else
					rdt_ = ~cells[addr[7:0]];
				rok_ = 1'b0;
			end
			// Keep the answer until the strobe goes back up
			held = 0;
			while ((!dr_ || !dw_) && held < 1000) begin
				@(posedge __clk);
				#5;
				held++;
			end
			if (held >= 1000) begin
				$display("Bus strobe was never released after the memory answered");
				faults++;
			end
			rok_ = 1'b1;
			ren_ = 1'b1;
			rdt_ = 16'hffff;
		end
	end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
	input logic __clk,
	input logic reset,

	// control panel
	input logic start_,
	input cpu_pkg::addr_t kl,
	output logic run,
	output logic hlt_n_,
	output logic awaria_,
	output cpu_pkg::word_t w,

	// system bus
	output logic dr_,
	output logic dw_,
	output cpu_pkg::addr_t dad_,
	output cpu_pkg::word_t ddt_,
	input cpu_pkg::word_t rdt_,
	input logic rok_,
	input logic ren_
);

	localparam cpu_pkg::word_t bus_released = `CPU_BUS_IDLE;

	fetch_if f_link();
	decode_if d_link();
	bus_if fetch_bus();
	bus_if exec_bus();

	logic flush;
	logic halt;
	cpu_pkg::addr_t target;
	cpu_pkg::addr_t px_dad_;
	cpu_pkg::word_t px_ddt_;

	// --------------------
	// Pipeline
	fetch_stage fetch (.__clk(__clk), .reset(reset), .start_(start_), .kl(kl), .run(run),
		.flush(flush), .target(target), .halt(halt), .bus(fetch_bus), .out(f_link));

	decode_stage decode (.__clk(__clk), .reset(reset), .flush(flush), .in(f_link),
		.out(d_link));

	execute_stage execute (.__clk(__clk), .reset(reset), .in(d_link), .bus(exec_bus),
		.flush(flush), .target(target), .halt(halt), .hlt_n_(hlt_n_), .awaria_(awaria_),
		.w(w));

	// --------------------
	// Bus sequencer
	px px (.__clk(__clk), .reset(reset), .fetch_bus(fetch_bus), .exec_bus(exec_bus),
		.dr_(dr_), .dw_(dw_), .dad_(px_dad_), .ddt_(px_ddt_), .rdt_(rdt_), .rok_(rok_),
		.ren_(ren_));

	// Open-collector merge, further sources AND in here
	assign dad_ = px_dad_ & bus_released;
	assign ddt_ = px_ddt_ & bus_released;

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
	input logic __clk,
	input logic reset,
	decode_if.sink in,
	bus_if.stage bus,
	output logic flush,
	output cpu_pkg::addr_t target,
	output logic halt,
	output logic hlt_n_,
	output logic awaria_,
	output cpu_pkg::word_t w
);

	cpu_pkg::exec_state_t state;
	cpu_pkg::word_t regs [0:`CPU_REG_N-1];
	cpu_pkg::word_t a_val;
	cpu_pkg::word_t c_val;
	cpu_pkg::word_t ea;
	cpu_pkg::word_t result;
	cpu_pkg::reg_idx_t load_dst;
	cpu_pkg::addr_t mem_addr;
	cpu_pkg::word_t mem_wdata;
	logic mem_we;
	logic req;
	logic fire;
	logic write_reg;
	logic mem_op;
	logic jump;
	logic stop_ok;
	logic stop_bad;

	assign in.ready = (state == cpu_pkg::ex_operate);
	assign fire = in.valid && in.ready;

	assign a_val = regs[in.ra];
	assign c_val = regs[in.rc];
	// C plus offset, for memory and jumps
	assign ea = c_val + in.imm;

	// --------------------
	// Arithmetic and logic
	always_comb begin
		result = a_val;
		write_reg = 1'b0;
		mem_op = 1'b0;
		jump = 1'b0;
		stop_ok = 1'b0;
		stop_bad = 1'b0;
		case (in.op)
			cpu_pkg::op_lwt: begin
				result = in.imm;
				write_reg = 1'b1;
			end
			cpu_pkg::op_aw: begin
				result = a_val + c_val;
				write_reg = 1'b1;
			end
			cpu_pkg::op_sw: begin
				result = a_val - c_val;
				write_reg = 1'b1;
			end
			cpu_pkg::op_nr: begin
				result = a_val & c_val;
				write_reg = 1'b1;
			end
			cpu_pkg::op_or: begin
				result = a_val | c_val;
				write_reg = 1'b1;
			end
			cpu_pkg::op_lw, cpu_pkg::op_rw: mem_op = 1'b1;
			cpu_pkg::op_uj: jump = 1'b1;
			cpu_pkg::op_hlt: stop_ok = 1'b1;
			default: stop_bad = 1'b1;
		endcase
	end

	// --------------------
	// Sequencing, write-back, lamps
	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= cpu_pkg::ex_operate;
			req <= 1'b0;
			hlt_n_ <= 1'b1;
			awaria_ <= 1'b1;
			w <= '0;
			for (int i = 0; i < `CPU_REG_N; i++)
				regs[i] <= '0;
		end else begin
			case (state)
				cpu_pkg::ex_operate: begin
					if (fire && write_reg) begin
						regs[in.ra] <= result;
						w <= result;
					end
					if (fire && mem_op) begin
						req <= 1'b1;
						state <= cpu_pkg::ex_mem_wait;
					end else if (fire && stop_ok) begin
						hlt_n_ <= 1'b0;
						state <= cpu_pkg::ex_halted;
					end else if (fire && stop_bad) begin
						awaria_ <= 1'b0;
						state <= cpu_pkg::ex_halted;
					end
				end
				cpu_pkg::ex_mem_wait: begin
					if (bus.done) begin
						req <= 1'b0;
						if (!mem_we) begin
							regs[load_dst] <= bus.rdata;
							w <= bus.rdata;
						end
						state <= cpu_pkg::ex_operate;
					end else if (bus.nomem) begin
						req <= 1'b0;
						awaria_ <= 1'b0;
						state <= cpu_pkg::ex_halted;
					end
				end
				default: state <= cpu_pkg::ex_halted;
			endcase
		end
	end

	always_ff @(posedge __clk) begin
		if (fire && mem_op) begin
			mem_we <= (in.op == cpu_pkg::op_rw);
			mem_addr <= ea;
			mem_wdata <= a_val;
			load_dst <= in.ra;
		end
	end

	assign bus.req = req;
	assign bus.we = mem_we;
	assign bus.addr = mem_addr;
	assign bus.wdata = mem_wdata;

	// Redirect in the same cycle the jump executes
	assign flush = fire && jump;
	assign target = ea;
	assign halt = (state == cpu_pkg::ex_halted);

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module decode_stage (
	input logic __clk,
	input logic reset,
	input logic flush,
	fetch_if.sink in,
	decode_if.source out
);

	logic valid;
	logic take;
	cpu_pkg::op_t op;
	cpu_pkg::reg_idx_t ra;
	cpu_pkg::reg_idx_t rc;
	cpu_pkg::word_t imm;
	cpu_pkg::addr_t last_pc;
	logic last_ok;

	function automatic cpu_pkg::op_t classify(input logic [0:3] code);
		case (code)
			`CPU_OP_LWT: return cpu_pkg::op_lwt;
			`CPU_OP_AW: return cpu_pkg::op_aw;
			`CPU_OP_SW: return cpu_pkg::op_sw;
			`CPU_OP_NR: return cpu_pkg::op_nr;
			`CPU_OP_OR: return cpu_pkg::op_or;
			`CPU_OP_LW: return cpu_pkg::op_lw;
			`CPU_OP_RW: return cpu_pkg::op_rw;
			`CPU_OP_UJ: return cpu_pkg::op_uj;
			`CPU_OP_HLT: return cpu_pkg::op_hlt;
			default: return cpu_pkg::op_ill;
		endcase
	endfunction

	assign in.ready = !valid || out.ready;
	assign take = in.valid && in.ready;

	always_ff @(posedge __clk) begin
		if (reset) begin
			valid <= 1'b0;
			last_ok <= 1'b0;
		end else begin
			if (flush)
				valid <= 1'b0;
			else if (take)
				valid <= 1'b1;
			else if (out.ready)
				valid <= 1'b0;
			// Cleared by a redirect, set by the next clean take
			if (flush)
				last_ok <= 1'b0;
			else if (take)
				last_ok <= 1'b1;
		end
	end

	// Fields: opcode 0..3, A 4..6, C 7..9, offset 10..15
	always_ff @(posedge __clk) begin
		if (take) begin
			op <= classify(in.ir[0:3]);
			ra <= in.ir[4:6];
			rc <= in.ir[7:9];
			imm <= {{(`CPU_WORD_W - 6){in.ir[10]}}, in.ir[10:15]};
			last_pc <= in.pc;
		end
	end

	assign out.valid = valid;
	assign out.op = op;
	assign out.ra = ra;
	assign out.rc = rc;
	assign out.imm = imm;

	assert property (@(posedge __clk) disable iff (reset) out.valid |-> !$isunknown(out.op));

	// Items taken with no redirect in between come from consecutive addresses
	assert property (@(posedge __clk) disable iff (reset)
		take && last_ok && !flush |-> in.pc == last_pc + 1'b1);

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module fetch_stage (
	input logic __clk,
	input logic reset,
	input logic start_,
	input cpu_pkg::addr_t kl,
	output logic run,
	input logic flush,
	input cpu_pkg::addr_t target,
	input logic halt,
	bus_if.stage bus,
	fetch_if.source out
);

	cpu_pkg::addr_t pc;
	cpu_pkg::addr_t fetch_pc;
	cpu_pkg::word_t ir;
	logic req;
	logic stale;
	logic slot;
	logic answered;
	logic issue;
	logic start_load;

	assign answered = req && (bus.done || bus.nomem);
	assign issue = !req && run && !halt && !slot && !flush;
	assign start_load = !start_ && !run && !halt;

	always_ff @(posedge __clk) begin
		if (reset) begin
			run <= 1'b0;
			pc <= '0;
			req <= 1'b0;
			stale <= 1'b0;
			slot <= 1'b0;
		end else begin
			if (halt)
				run <= 1'b0;
			else if (start_load)
				run <= 1'b1;

			if (flush)
				pc <= target;
			else if (start_load)
				pc <= kl;
			else if (answered && !stale)
				pc <= pc + 1'b1;

			if (answered)
				req <= 1'b0;
			else if (issue)
				req <= 1'b1;

			// A read still on the bus during a redirect is thrown away
			if (answered)
				stale <= 1'b0;
			else if (flush && req)
				stale <= 1'b1;

			if (flush)
				slot <= 1'b0;
			else if (answered && !stale)
				slot <= 1'b1;
			else if (out.ready)
				slot <= 1'b0;
		end
	end

	// Missing memory is passed on as an illegal word, execute raises the alarm
	always_ff @(posedge __clk) begin
		if (issue)
			fetch_pc <= pc;
		if (answered && !stale)
			ir <= bus.done ? bus.rdata : `CPU_BUS_IDLE;
	end

	assign bus.req = req;
	assign bus.we = 1'b0;
	assign bus.addr = fetch_pc;
	assign bus.wdata = '0;

	assign out.valid = slot;
	assign out.pc = fetch_pc;
	assign out.ir = ir;

endmodule

// ==== hw/px.sv ====
`timescale 1ns/1ps
`include "cpu_settings.svh"

module px (
	input logic __clk,
	input logic reset,
	bus_if.sequencer fetch_bus,
	bus_if.sequencer exec_bus,
	output logic dr_,
	output logic dw_,
	output cpu_pkg::addr_t dad_,
	output cpu_pkg::word_t ddt_,
	input cpu_pkg::word_t rdt_,
	input logic rok_,
	input logic ren_
);

	cpu_pkg::bus_state_t state;
	logic sel_exec;
	logic done_q;
	logic nomem_q;
	logic we_q;
	cpu_pkg::addr_t addr_q;
	cpu_pkg::word_t wdata_q;
	cpu_pkg::word_t rdata_q;
	logic bus_free;
	logic strobe;

	// Both answer lines back high, previous cycle fully closed
	assign bus_free = rok_ && ren_;
	assign strobe = (state == cpu_pkg::bus_strobe);

	// --------------------
	// Sequencer FSM and arbiter

	always_ff @(posedge __clk) begin
		if (reset) begin
			state <= cpu_pkg::bus_idle;
			sel_exec <= 1'b0;
			done_q <= 1'b0;
			nomem_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			nomem_q <= 1'b0;
			case (state)
				cpu_pkg::bus_idle: begin
					// Execute has priority over fetch
					if (bus_free && (exec_bus.req || fetch_bus.req)) begin
						sel_exec <= exec_bus.req;
						state <= cpu_pkg::bus_strobe;
					end
				end
				cpu_pkg::bus_strobe: begin
					if (!rok_) begin
						done_q <= 1'b1;
						state <= cpu_pkg::bus_release;
					end else if (!ren_) begin
						nomem_q <= 1'b1;
						state <= cpu_pkg::bus_release;
					end
				end
				cpu_pkg::bus_release: begin
					if (bus_free)
						state <= cpu_pkg::bus_idle;
				end
				default: state <= cpu_pkg::bus_idle;
			endcase
		end
	end

	// Request fields follow the winner until the strobe starts
	always_ff @(posedge __clk) begin
		if (state == cpu_pkg::bus_idle) begin
			we_q <= exec_bus.req ? exec_bus.we : fetch_bus.we;
			addr_q <= exec_bus.req ? exec_bus.addr : fetch_bus.addr;
			wdata_q <= exec_bus.req ? exec_bus.wdata : fetch_bus.wdata;
		end
		if (strobe && !rok_)
			rdata_q <= ~rdt_;
	end

	// --------------------
	// Active-low bus side
	assign dr_ = !(strobe && !we_q);
	assign dw_ = !(strobe && we_q);
	assign dad_ = strobe ? ~addr_q : `CPU_BUS_IDLE;
	assign ddt_ = (strobe && we_q) ? ~wdata_q : `CPU_BUS_IDLE;

	assign fetch_bus.rdata = rdata_q;
	assign fetch_bus.done = done_q && !sel_exec;
	assign fetch_bus.nomem = nomem_q && !sel_exec;
	assign exec_bus.rdata = rdata_q;
	assign exec_bus.done = done_q && sel_exec;
	assign exec_bus.nomem = nomem_q && sel_exec;

	// Never a read and a write on the bus at once
	assert property (@(posedge __clk) disable iff (reset) !(!dr_ && !dw_));

	// A strobe stays down until memory answers
	assert property (@(posedge __clk) disable iff (reset)
		(!dr_ || !dw_) && rok_ && ren_ |=> (!dr_ || !dw_));

endmodule

// ==== hw/bus_if.sv ====
`timescale 1ns/1ps

// One stage's access request to the bus sequencer
interface bus_if;

	logic req;
	logic we;
	cpu_pkg::addr_t addr;
	cpu_pkg::word_t wdata;
	cpu_pkg::word_t rdata;
	// One-cycle pulses closing the request
	logic done;
	logic nomem;

	modport stage (
		output req, we, addr, wdata,
		input rdata, done, nomem
	);

	modport sequencer (
		input req, we, addr, wdata,
		output rdata, done, nomem
	);

endinterface

// ==== hw/decode_if.sv ====
`timescale 1ns/1ps

// Decoded operation on its way to execute
interface decode_if;

	logic valid;
	logic ready;
	cpu_pkg::op_t op;
	// Destination or store source
	cpu_pkg::reg_idx_t ra;
	// Operand or base
	cpu_pkg::reg_idx_t rc;
	// Offset, already sign extended
	cpu_pkg::word_t imm;

	modport source (
		output valid,
		output op,
		output ra,
		output rc,
		output imm,
		input ready
	);

	modport sink (
		input valid,
		input op,
		input ra,
		input rc,
		input imm,
		output ready
	);

endinterface

// ==== hw/fetch_if.sv ====
`timescale 1ns/1ps

// Fetched instruction on its way to decode
interface fetch_if;

	logic valid;
	logic ready;
	// Address the word was read from
	cpu_pkg::addr_t pc;
	cpu_pkg::word_t ir;

	modport source (
		output valid,
		output pc,
		output ir,
		input ready
	);

	modport sink (
		input valid,
		input pc,
		input ir,
		output ready
	);

endinterface

// ==== hw/cpu_pkg.sv ====
`include "cpu_settings.svh"

package cpu_pkg;

	// Bit 0 is the most significant bit
	typedef logic [0:`CPU_WORD_W-1] word_t;
	typedef logic [0:`CPU_WORD_W-1] addr_t;
	typedef logic [0:$clog2(`CPU_REG_N)-1] reg_idx_t;

	// Operation class handed from decode to execute
	typedef logic [0:3] op_t;

	localparam op_t op_lwt = 4'd0;
	localparam op_t op_aw = 4'd1;
	localparam op_t op_sw = 4'd2;
	localparam op_t op_nr = 4'd3;
	localparam op_t op_or = 4'd4;
	localparam op_t op_lw = 4'd5;
	localparam op_t op_rw = 4'd6;
	localparam op_t op_uj = 4'd7;
	localparam op_t op_hlt = 4'd8;
	localparam op_t op_ill = 4'd15;

	typedef enum logic [1:0] {
		bus_idle,
		bus_strobe,
		bus_release
	} bus_state_t;

	typedef enum logic [1:0] {
		ex_operate,
		ex_mem_wait,
		ex_halted
	} exec_state_t;

endpackage

// ==== hw/cpu_settings.svh ====
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Word and register file geometry
`define CPU_WORD_W 16
`define CPU_REG_N 8

// --------------------
// Opcodes in bits 0..3 of the instruction word
// Codes not listed here are illegal
`define CPU_OP_LWT 4'h1
`define CPU_OP_AW 4'h2
`define CPU_OP_SW 4'h3
`define CPU_OP_NR 4'h4
`define CPU_OP_OR 4'h5
`define CPU_OP_LW 4'h8
`define CPU_OP_RW 4'h9
`define CPU_OP_UJ 4'hc
`define CPU_OP_HLT 4'he

// Released state of an active-low bus field
`define CPU_BUS_IDLE {`CPU_WORD_W{1'b1}}

`endif
